// File: verilog.f
common/buffer_cfg_pkg.sv
common/capture_state_pkg.sv
hdl/capture_fsm.sv
hdl/write_addr_counter.sv
hdl/sample_mem.sv
readout/readout_engine.sv
hdl/sample_buffer.sv
test/sample_buffer_properties.sv
test/sample_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run sample_buffer_tb with Verilator, fail on a build error,
# a bad exit status or a fail line in the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module sample_buffer_tb \
  -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vsample_buffer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0

// File: test/sample_buffer_tb.sv
// fixed seed 88996, BUFFER_DEPTH 16 and READ_LATENCY 3; inputs change on the falling edge, outputs sampled 1 ns before the rising edge
`timescale 1ns/1ps

module sample_buffer_tb
  import buffer_cfg_pkg::*;
();

  localparam int BUFFER_DEPTH = 16;
  localparam int READ_LATENCY = 3;
  localparam int CNT_W        = $clog2(CHANNELS * BUFFER_DEPTH) + 1;
  // eight tests, each well inside four passes over both banks plus slack
  localparam int TIMEOUT      = 8 * (4 * 2 * CHANNELS * BUFFER_DEPTH + 200);
  localparam int RD_WINDOW    = 4 * CHANNELS * BUFFER_DEPTH + 50;

  logic                                  ps_clk;
  logic                                  arst_n_i;
  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] adc_data_i;
  logic                                  adc_valid_i, hw_start_i, hw_stop_i, arm_i;
  logic                                  capture_sw_reset_i, readout_sw_reset_i, readout_start_i;
  bank_mode_t                            bank_mode_i;
  logic                                  depth_ready_i, rd_ready_i;
  logic                                  capture_ready_o, capture_full_o, depth_valid_o;
  logic [CHANNELS-1:0][CNT_W-1:0]        depth_o;
  logic                                  rd_valid_o, rd_last_o;
  logic [SAMPLE_WIDTH-1:0]               rd_data_o;

  // scoreboard state shared by the stimulus and the comparing process
  integer                  seed = 88996;
  int                      errors = 0;
  int                      checks = 0;
  int                      cycles = 0;
  int                      reports, fulls, rd_idx, lasts;
  logic [SAMPLE_WIDTH-1:0] rec0[$], rec1[$], exp_seq[$];
  int                      exp_depth [CHANNELS];

  sample_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH), .READ_LATENCY(READ_LATENCY)) dut_i (.*);

  bind capture_fsm sample_buffer_properties props_i (.*);

  initial ps_clk = 1'b0;
  always #5 ps_clk = ~ps_clk;

  // expected depth fields and readout order, built from the recorded samples
  function automatic void build_reference(input bit mode);
    exp_seq      = rec0;
    exp_depth[0] = rec0.size();
    exp_depth[1] = 0;
    // mode 0 appends channel 1 after all of channel 0
    if (!mode) begin
      exp_depth[1] = rec1.size();
      foreach (rec1[i]) exp_seq.push_back(rec1[i]);
    end
  endfunction

  // compare every handshake just before the edge that takes it
  always @(negedge ps_clk) begin
    #4;
    cycles++;
    if (depth_valid_o && depth_ready_i) begin
      reports++;
      for (int c = 0; c < CHANNELS; c++) begin
        checks++;
        if (int'(depth_o[c]) != exp_depth[c]) begin
          errors++;
          $display("MISMATCH at %0t: depth ch%0d got %0d expected %0d",
                   $time, c, depth_o[c], exp_depth[c]);
        end
      end
    end
    if (rd_valid_o && rd_ready_i) begin
      checks++;
      if (rd_idx >= exp_seq.size()) begin
        errors++;
        $display("MISMATCH at %0t: word %h beyond the expected stream", $time, rd_data_o);
      end else if (rd_data_o !== exp_seq[rd_idx] ||
                   rd_last_o !== (rd_idx == exp_seq.size() - 1)) begin
        errors++;
        $display("MISMATCH at %0t: word %0d got %h last %b expected %h",
                 $time, rd_idx, rd_data_o, rd_last_o, exp_seq[rd_idx]);
      end
      if (rd_last_o) lasts++;
      rd_idx++;
    end
    if (capture_full_o) fulls++;
    if (cycles > TIMEOUT) begin
      $display("run stopped by the timeout after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic clear_scoreboard();
    rec0.delete();
    rec1.delete();
    reports = 0;
    fulls   = 0;
    rd_idx  = 0;
    lasts   = 0;
  endtask

  // ready flag is high exactly while the pulses sent so far leave the machine armed
  task automatic verify_ready(input logic exp_ready);
    checks++;
    if (capture_ready_o !== exp_ready) begin
      errors++;
      $display("MISMATCH at %0t: capture_ready_o got %b expected %b",
               $time, capture_ready_o, exp_ready);
    end
  endtask

  // arm on one falling edge, start trigger on the next
  task automatic arm_and_start(input bit mode);
    @(negedge ps_clk);
    bank_mode_i = bank_mode_t'(mode);
    arm_i       = 1'b1;
    @(negedge ps_clk);
    arm_i       = 1'b0;
    hw_start_i  = 1'b1;
    verify_ready(1'b1);
  endtask

  // nstop 0 runs until full, abort ends with a capture reset instead of a stop
  task automatic capture(input bit mode, input int nstop, input bit abort);
    int limit;
    limit = mode ? 2 * BUFFER_DEPTH : BUFFER_DEPTH;
    clear_scoreboard();
    arm_and_start(mode);
    while (rec0.size() < limit && (nstop == 0 || rec0.size() < nstop)) begin
      @(negedge ps_clk);
      hw_start_i    = 1'b0;
      // roughly one cycle in four without a sample
      adc_valid_i   = ($random(seed) % 4) != 0;
      adc_data_i[0] = SAMPLE_WIDTH'($random(seed));
      adc_data_i[1] = SAMPLE_WIDTH'($random(seed));
      if (adc_valid_i) begin
        rec0.push_back(adc_data_i[0]);
        rec1.push_back(adc_data_i[1]);
      end
      if (nstop != 0 && rec0.size() == nstop) begin
        hw_stop_i          = !abort;
        capture_sw_reset_i = abort;
      end
    end
    @(negedge ps_clk);
    adc_valid_i        = 1'b0;
    hw_stop_i          = 1'b0;
    capture_sw_reset_i = 1'b0;
    verify_ready(1'b0);
    build_reference(mode);
  endtask

  // report arrives one cycle after HOLD, a few more cycles catch a second one
  task automatic check_reports(input int exp_reports, input int exp_fulls);
    for (int i = 0; i < 10 && reports < exp_reports; i++) @(negedge ps_clk);
    repeat (4) @(negedge ps_clk);
    if (reports != exp_reports || fulls != exp_fulls) begin
      errors++;
      $display("expected %0d depth report(s) and %0d full flag(s) but saw %0d and %0d",
               exp_reports, exp_fulls, reports, fulls);
    end
  endtask

  // reset_at of 0 or more flushes the readout after that many words and returns
  task automatic run_readout(input bit random_ready, input int reset_at);
    int wait_cnt;
    int exp_lasts;
    exp_lasts = (exp_seq.size() != 0) ? 1 : 0;
    wait_cnt  = 0;
    @(negedge ps_clk);
    readout_start_i = 1'b1;
    while (lasts == 0 && wait_cnt < RD_WINDOW) begin
      @(negedge ps_clk);
      readout_start_i = 1'b0;
      rd_ready_i      = random_ready ? ($random(seed) % 2 != 0) : 1'b1;
      if (reset_at >= 0 && rd_idx >= reset_at) begin
        // no handshake in the flush cycle
        rd_ready_i         = 1'b0;
        readout_sw_reset_i = 1'b1;
        @(negedge ps_clk);
        readout_sw_reset_i = 1'b0;
        rd_idx             = 0;
        return;
      end
      wait_cnt++;
    end
    @(negedge ps_clk);
    rd_ready_i = 1'b1;
    if (rd_idx != exp_seq.size() || lasts != exp_lasts) begin
      errors++;
      $display("readout delivered %0d of %0d words and %0d last marker(s)",
               rd_idx, exp_seq.size(), lasts);
    end
  endtask

  initial begin
    int nstop;
    arst_n_i           = 1'b0;
    adc_data_i         = '0;
    adc_valid_i        = 1'b0;
    hw_start_i         = 1'b0;
    hw_stop_i          = 1'b0;
    arm_i              = 1'b0;
    capture_sw_reset_i = 1'b0;
    readout_sw_reset_i = 1'b0;
    readout_start_i    = 1'b0;
    bank_mode_i        = MODE_ALL_CHANNELS;
    depth_ready_i      = 1'b1;
    rd_ready_i         = 1'b1;
    clear_scoreboard();
    build_reference(1'b0);
    repeat (8) @(negedge ps_clk);
    arst_n_i = 1'b1;
    verify_ready(1'b0);
    // capture until full in both banking modes
    for (int m = 0; m < 2; m++) begin
      capture(m[0], 0, 1'b0);
      check_reports(1, 1);
      run_readout(1'b0, -1);
    end
    // stop after a random number of samples, mode 1 may cross into bank 1
    for (int m = 0; m < 2; m++) begin
      nstop = 1 + int'($unsigned($random(seed)) % (BUFFER_DEPTH * (m + 1) - 1));
      capture(m[0], nstop, 1'b0);
      check_reports(1, 0);
      run_readout(1'b1, -1);
    end
    // start trigger without an arm, then a readout start that must stay silent
    clear_scoreboard();
    build_reference(1'b0);
    @(negedge ps_clk);
    hw_start_i  = 1'b1;
    adc_valid_i = 1'b1;
    @(negedge ps_clk);
    hw_start_i  = 1'b0;
    adc_valid_i = 1'b0;
    verify_ready(1'b0);
    run_readout(1'b0, -1);
    check_reports(0, 0);
    // capture reset in ARMED
    clear_scoreboard();
    @(negedge ps_clk);
    arm_i = 1'b1;
    @(negedge ps_clk);
    arm_i              = 1'b0;
    capture_sw_reset_i = 1'b1;
    verify_ready(1'b1);
    @(negedge ps_clk);
    capture_sw_reset_i = 1'b0;
    verify_ready(1'b0);
    check_reports(0, 0);
    // capture reset in CAPTURE
    capture(1'b0, 5, 1'b1);
    check_reports(0, 0);
    // capture reset in HOLD while the report waits for ready
    depth_ready_i = 1'b0;
    capture(1'b0, 5, 1'b0);
    repeat (2) @(negedge ps_clk);
    capture_sw_reset_i = 1'b1;
    @(negedge ps_clk);
    capture_sw_reset_i = 1'b0;
    depth_ready_i      = 1'b1;
    check_reports(0, 0);
    clear_scoreboard();
    build_reference(1'b0);
    run_readout(1'b0, -1);
    // full capture from a clean start
    capture(1'b0, 0, 1'b0);
    check_reports(1, 1);
    run_readout(1'b0, -1);
    // readout reset halfway under back-pressure, then a reset in HOLD that is ignored
    capture(1'b0, 0, 1'b0);
    check_reports(1, 1);
    run_readout(1'b1, CHANNELS * BUFFER_DEPTH / 2);
    @(negedge ps_clk);
    readout_sw_reset_i = 1'b1;
    @(negedge ps_clk);
    readout_sw_reset_i = 1'b0;
    run_readout(1'b1, -1);
    check_reports(1, 1);
    repeat (5) @(negedge ps_clk);
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: test/sample_buffer_properties.sv
// bound to capture_fsm by the testbench; all assertions are off while arst_n_i is low
`timescale 1ns/1ps

module sample_buffer_properties
  import capture_state_pkg::*;
(
  input logic           ps_clk,
  input logic           arst_n_i,
  input logic           arm_i,
  input logic           hw_start_i,
  input logic           hw_stop_i,
  input logic           capture_sw_reset_i,
  input logic           readout_sw_reset_i,
  input logic           readout_start_i,
  input logic           full_i,
  input logic           readout_done_i,
  input logic           depth_ready_i,
  input capture_state_t state_o,
  input logic           depth_valid_o
);

  // no input other than the start trigger that could move the state
  logic others_quiet;

  assign others_quiet = !(arm_i || hw_stop_i || full_i || capture_sw_reset_i ||
                          readout_sw_reset_i || readout_start_i || readout_done_i);

  state_legal: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    state_o inside {IDLE, ARMED, CAPTURE, HOLD, READOUT})
    else $error("capture state holds an illegal code");

  // only a capture reset may withdraw a pending report
  depth_held: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    depth_valid_o && !depth_ready_i && !capture_sw_reset_i |=> depth_valid_o)
    else $error("depth report dropped before depth_ready_i");

  start_ignored: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    hw_start_i && (state_o != ARMED) && others_quiet |=> $stable(state_o))
    else $error("start trigger outside ARMED changed the state");

endmodule

// File: hdl/sample_buffer.sv
// single clock domain, hardware triggers only; BUFFER_DEPTH a power of two, READ_LATENCY at least 1
`timescale 1ns/1ps

module sample_buffer
  import buffer_cfg_pkg::*;
  import capture_state_pkg::*;
#(
  parameter  int BUFFER_DEPTH = 64,
  parameter  int READ_LATENCY = 3,
  localparam int ADDR_W       = $clog2(BUFFER_DEPTH),
  localparam int CNT_W        = $clog2(CHANNELS * BUFFER_DEPTH) + 1
) (
  input  logic                                  ps_clk,
  input  logic                                  arst_n_i,
  input  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] adc_data_i,
  input  logic                                  adc_valid_i,
  input  logic                                  hw_start_i,
  input  logic                                  hw_stop_i,
  input  logic                                  arm_i,
  input  logic                                  capture_sw_reset_i,
  input  logic                                  readout_sw_reset_i,
  input  logic                                  readout_start_i,
  input  bank_mode_t                            bank_mode_i,
  output logic                                  capture_ready_o,
  output logic                                  capture_full_o,
  output logic                                  depth_valid_o,
  input  logic                                  depth_ready_i,
  output logic [CHANNELS-1:0][CNT_W-1:0]        depth_o,
  output logic                                  rd_valid_o,
  input  logic                                  rd_ready_i,
  output logic [SAMPLE_WIDTH-1:0]               rd_data_o,
  output logic                                  rd_last_o
);

  capture_state_t                  state;
  // banking mode as latched at arm time
  bank_mode_t                      bank_mode;
  logic                            counter_clear;
  logic                            readout_flush;
  logic                            readout_done;
  logic [CHANNELS-1:0]             wr_en;
  logic [CHANNELS-1:0][ADDR_W-1:0] wr_addr;
  logic                            mem_rd_en;
  logic [BANK_SEL_WIDTH-1:0]       mem_rd_bank;
  logic [ADDR_W-1:0]               mem_rd_addr;
  logic [SAMPLE_WIDTH-1:0]         mem_rd_data;

  capture_fsm fsm_i (
    .ps_clk, .arst_n_i, .arm_i, .hw_start_i, .hw_stop_i,
    .capture_sw_reset_i, .readout_sw_reset_i, .readout_start_i, .bank_mode_i,
    .full_i          (capture_full_o),
    .readout_done_i  (readout_done),
    .depth_ready_i,
    .state_o         (state),
    .bank_mode_o     (bank_mode),
    .counter_clear_o (counter_clear),
    .readout_flush_o (readout_flush),
    .depth_valid_o,
    .capture_ready_o
  );

  // the counts double as the depth report
  write_addr_counter #(.BUFFER_DEPTH(BUFFER_DEPTH)) counter_i (
    .ps_clk, .arst_n_i,
    .clear_i     (counter_clear),
    .write_en_i  (adc_valid_i),
    .state_i     (state),
    .bank_mode_i (bank_mode),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .count_o     (depth_o),
    .full_o      (capture_full_o)
  );

  sample_mem #(.BUFFER_DEPTH(BUFFER_DEPTH), .READ_LATENCY(READ_LATENCY)) mem_i (
    .ps_clk,
    .bank_mode_i (bank_mode),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (adc_data_i),
    .rd_en_i     (mem_rd_en),
    .rd_bank_i   (mem_rd_bank),
    .rd_addr_i   (mem_rd_addr),
    .rd_data_o   (mem_rd_data)
  );

  readout_engine #(.BUFFER_DEPTH(BUFFER_DEPTH), .READ_LATENCY(READ_LATENCY)) readout_i (
    .ps_clk, .arst_n_i,
    .active_i      (state == READOUT),
    .flush_i       (readout_flush),
    .bank_mode_i   (bank_mode),
    .count_i       (depth_o),
    .mem_data_i    (mem_rd_data),
    .rd_ready_i,
    .mem_rd_en_o   (mem_rd_en),
    .mem_rd_bank_o (mem_rd_bank),
    .mem_rd_addr_o (mem_rd_addr),
    .rd_valid_o, .rd_data_o, .rd_last_o,
    .done_o        (readout_done)
  );

endmodule

// File: readout/readout_engine.sv
// two-bank sequencing only (CHANNELS = 2); an empty capture completes its readout at once without data
`timescale 1ns/1ps

module readout_engine
  import buffer_cfg_pkg::*;
#(
  parameter  int BUFFER_DEPTH = 64,
  parameter  int READ_LATENCY = 3,
  localparam int ADDR_W       = $clog2(BUFFER_DEPTH),
  localparam int CNT_W        = $clog2(CHANNELS * BUFFER_DEPTH) + 1
) (
  input  logic                            ps_clk,
  input  logic                            arst_n_i,
  input  logic                            active_i,
  input  logic                            flush_i,
  input  bank_mode_t                      bank_mode_i,
  input  logic [CHANNELS-1:0][CNT_W-1:0]  count_i,
  input  logic [SAMPLE_WIDTH-1:0]         mem_data_i,
  input  logic                            rd_ready_i,
  output logic                            mem_rd_en_o,
  output logic [BANK_SEL_WIDTH-1:0]       mem_rd_bank_o,
  output logic [ADDR_W-1:0]               mem_rd_addr_o,
  output logic                            rd_valid_o,
  output logic [SAMPLE_WIDTH-1:0]         rd_data_o,
  output logic                            rd_last_o,
  output logic                            done_o
);

  // one slot per read in flight plus one for the word on the output
  localparam int QDEPTH = READ_LATENCY + 1;
  localparam int QPTR_W = $clog2(QDEPTH);
  localparam int QCNT_W = $clog2(QDEPTH + 1);

  logic [CNT_W-1:0]        total;
  // first read index that falls into bank 1
  logic [CNT_W-1:0]        boundary;
  logic [CNT_W-1:0]        rd_idx_q;
  logic [CNT_W-1:0]        offset;
  logic                    bank_hi;
  logic [READ_LATENCY-1:0] vld_pipe_q;
  logic [READ_LATENCY-1:0] last_pipe_q;
  logic [QCNT_W-1:0]       inflight;
  logic [QCNT_W-1:0]       q_cnt_q;
  logic [QPTR_W-1:0]       q_wr_ptr_q;
  logic [QPTR_W-1:0]       q_rd_ptr_q;
  logic [SAMPLE_WIDTH-1:0] q_data [QDEPTH];
  logic                    q_last [QDEPTH];
  logic                    issue;
  logic                    q_push;
  logic                    q_pop;

  function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
    return (ptr == QPTR_W'(QDEPTH - 1)) ? '0 : ptr + QPTR_W'(1);
  endfunction

  // channel 1 count is zero in chained mode, so the sum is the stream length
  assign total    = count_i[0] + count_i[1];
  assign boundary = (bank_mode_i == MODE_CH0_ONLY) ? CNT_W'(BUFFER_DEPTH) : count_i[0];
  assign bank_hi  = (rd_idx_q >= boundary);
  assign offset   = bank_hi ? (rd_idx_q - boundary) : rd_idx_q;

  always_comb begin
    inflight = '0;
    for (int s = 0; s < READ_LATENCY; s++) begin
      inflight = inflight + QCNT_W'(vld_pipe_q[s]);
    end
  end

  // issue only when every read in flight still finds a free slot
  assign issue = active_i && !flush_i && (rd_idx_q < total) &&
                 ((QCNT_W'(QDEPTH) - q_cnt_q) > inflight);

  assign mem_rd_en_o   = issue;
  assign mem_rd_bank_o = BANK_SEL_WIDTH'(bank_hi);
  assign mem_rd_addr_o = offset[ADDR_W-1:0];

  // the pipe output lines up with the memory data
  assign q_push     = vld_pipe_q[READ_LATENCY-1];
  assign rd_valid_o = (q_cnt_q != '0);
  assign q_pop      = rd_valid_o && rd_ready_i;
  assign rd_data_o  = q_data[q_rd_ptr_q];
  assign rd_last_o  = rd_valid_o && q_last[q_rd_ptr_q];
  assign done_o     = (q_pop && rd_last_o) || (active_i && (total == '0));

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_idx_q    <= '0;
      vld_pipe_q  <= '0;
      last_pipe_q <= '0;
      q_cnt_q     <= '0;
      q_wr_ptr_q  <= '0;
      q_rd_ptr_q  <= '0;
    end else if (flush_i) begin
      // words still in the memory pipe are forgotten with their valid bits
      rd_idx_q    <= '0;
      vld_pipe_q  <= '0;
      last_pipe_q <= '0;
      q_cnt_q     <= '0;
      q_wr_ptr_q  <= '0;
      q_rd_ptr_q  <= '0;
    end else begin
      if (done_o) rd_idx_q <= '0;
      else if (issue) rd_idx_q <= rd_idx_q + CNT_W'(1);
      vld_pipe_q  <= READ_LATENCY'({vld_pipe_q, issue});
      last_pipe_q <= READ_LATENCY'({last_pipe_q, issue && (rd_idx_q == total - CNT_W'(1))});
      q_cnt_q     <= q_cnt_q + QCNT_W'(q_push) - QCNT_W'(q_pop);
      if (q_push) q_wr_ptr_q <= next_ptr(q_wr_ptr_q);
      if (q_pop) q_rd_ptr_q <= next_ptr(q_rd_ptr_q);
    end
  end

  // queue payload
  always_ff @(posedge ps_clk) begin
    if (q_push) begin
      q_data[q_wr_ptr_q] <= mem_data_i;
      q_last[q_wr_ptr_q] <= last_pipe_q[READ_LATENCY-1];
    end
  end

endmodule

// File: hdl/sample_mem.sv
// no reset on the arrays or the read pipeline; read data is only meaningful READ_LATENCY cycles after rd_en_i
`timescale 1ns/1ps

module sample_mem
  import buffer_cfg_pkg::*;
#(
  parameter  int BUFFER_DEPTH = 64,
  parameter  int READ_LATENCY = 3,
  localparam int ADDR_W       = $clog2(BUFFER_DEPTH)
) (
  input  logic                                  ps_clk,
  input  bank_mode_t                            bank_mode_i,
  input  logic [CHANNELS-1:0]                   wr_en_i,
  input  logic [CHANNELS-1:0][ADDR_W-1:0]       wr_addr_i,
  input  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] wr_data_i,
  input  logic                                  rd_en_i,
  input  logic [BANK_SEL_WIDTH-1:0]             rd_bank_i,
  input  logic [ADDR_W-1:0]                     rd_addr_i,
  output logic [SAMPLE_WIDTH-1:0]               rd_data_o
);

  // one array per bank
  logic [SAMPLE_WIDTH-1:0] mem_q [CHANNELS][BUFFER_DEPTH];
  // stage 0 is the array output register
  logic [SAMPLE_WIDTH-1:0] rd_pipe_q [READ_LATENCY];

  always_ff @(posedge ps_clk) begin
    for (int b = 0; b < CHANNELS; b++) begin
      if (wr_en_i[b]) begin
        // in chained mode every bank takes its data from channel 0
        if (bank_mode_i == MODE_CH0_ONLY) mem_q[b][wr_addr_i[b]] <= wr_data_i[0];
        else mem_q[b][wr_addr_i[b]] <= wr_data_i[b];
      end
    end
  end

  // reads can be issued every cycle, each one travels down the pipe
  always_ff @(posedge ps_clk) begin
    if (rd_en_i) rd_pipe_q[0] <= mem_q[rd_bank_i][rd_addr_i];
    for (int s = 1; s < READ_LATENCY; s++) begin
      rd_pipe_q[s] <= rd_pipe_q[s-1];
    end
  end

  assign rd_data_o = rd_pipe_q[READ_LATENCY-1];

endmodule

// File: hdl/write_addr_counter.sv
// BUFFER_DEPTH must be a power of two; writes beyond the last active location are dropped
`timescale 1ns/1ps

module write_addr_counter
  import buffer_cfg_pkg::*;
  import capture_state_pkg::*;
#(
  parameter  int BUFFER_DEPTH = 64,
  localparam int ADDR_W       = $clog2(BUFFER_DEPTH),
  localparam int CNT_W        = $clog2(CHANNELS * BUFFER_DEPTH) + 1
) (
  input  logic                             ps_clk,
  input  logic                             arst_n_i,
  input  logic                             clear_i,
  input  logic                             write_en_i,
  input  capture_state_t                   state_i,
  input  bank_mode_t                       bank_mode_i,
  output logic [CHANNELS-1:0]              wr_en_o,
  output logic [CHANNELS-1:0][ADDR_W-1:0]  wr_addr_o,
  output logic [CHANNELS-1:0][CNT_W-1:0]   count_o,
  output logic                             full_o
);

  logic [CHANNELS-1:0][CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0]               limit;
  // bank currently filled by channel 0 in chained mode
  logic [BANK_SEL_WIDTH-1:0]      chain_bank;
  logic                           write;

  // active locations for channel 0, the other channels follow it in mode 0
  assign limit = (bank_mode_i == MODE_CH0_ONLY) ? CNT_W'(CHANNELS * BUFFER_DEPTH)
                                                : CNT_W'(BUFFER_DEPTH);
  assign write = write_en_i && (state_i == CAPTURE) && (cnt_q[0] < limit);
  // high in the cycle of the write that fills the last active location
  assign full_o = write && (cnt_q[0] == limit - CNT_W'(1));
  assign chain_bank = cnt_q[0][ADDR_W +: BANK_SEL_WIDTH];

  always_comb begin
    for (int b = 0; b < CHANNELS; b++) begin
      if (bank_mode_i == MODE_CH0_ONLY) begin
        // low count bits are the address inside whichever bank is being filled
        wr_en_o[b]   = write && (chain_bank == BANK_SEL_WIDTH'(b));
        wr_addr_o[b] = cnt_q[0][ADDR_W-1:0];
      end else begin
        wr_en_o[b]   = write;
        wr_addr_o[b] = cnt_q[b][ADDR_W-1:0];
      end
    end
  end

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (write) begin
      // channel 1 keeps its zero count in chained mode
      for (int c = 0; c < CHANNELS; c++) begin
        if ((c == 0) || (bank_mode_i == MODE_ALL_CHANNELS)) cnt_q[c] <= cnt_q[c] + CNT_W'(1);
      end
    end
  end

  assign count_o = cnt_q;

endmodule

// File: hdl/capture_fsm.sv
// pulses that arrive in a state which does not accept them are dropped; capture reset is ignored in IDLE and READOUT
`timescale 1ns/1ps

module capture_fsm
  import buffer_cfg_pkg::*;
  import capture_state_pkg::*;
(
  input  logic           ps_clk,
  input  logic           arst_n_i,
  input  logic           arm_i,
  input  logic           hw_start_i,
  input  logic           hw_stop_i,
  input  logic           capture_sw_reset_i,
  input  logic           readout_sw_reset_i,
  input  logic           readout_start_i,
  input  bank_mode_t     bank_mode_i,
  input  logic           full_i,
  input  logic           readout_done_i,
  input  logic           depth_ready_i,
  output capture_state_t state_o,
  output bank_mode_t     bank_mode_o,
  output logic           counter_clear_o,
  output logic           readout_flush_o,
  output logic           depth_valid_o,
  output logic           capture_ready_o
);

  capture_state_t state_q;
  capture_state_t state_d;
  bank_mode_t     bank_mode_q;
  logic           depth_valid_q;
  // set once the report of the current capture has been offered
  logic           depth_sent_q;
  logic           arm_take;
  logic           cap_rst_take;
  logic           rd_rst_take;

  // pulses that take effect in the current state
  assign arm_take     = (state_q == IDLE) && arm_i;
  assign cap_rst_take = capture_sw_reset_i &&
                        ((state_q == ARMED) || (state_q == CAPTURE) || (state_q == HOLD));
  assign rd_rst_take  = (state_q == READOUT) && readout_sw_reset_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (arm_i) state_d = ARMED;
      end
      ARMED: begin
        if (cap_rst_take) state_d = IDLE;
        else if (hw_start_i) state_d = CAPTURE;
      end
      CAPTURE: begin
        // stop and full both end the capture on the next edge
        if (cap_rst_take) state_d = IDLE;
        else if (hw_stop_i || full_i) state_d = HOLD;
      end
      HOLD: begin
        if (cap_rst_take) state_d = IDLE;
        else if (readout_start_i) state_d = READOUT;
      end
      READOUT: begin
        // readout reset wins over a done in the same cycle
        if (rd_rst_take) state_d = HOLD;
        else if (readout_done_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= IDLE;
      bank_mode_q   <= MODE_ALL_CHANNELS;
      depth_valid_q <= 1'b0;
      depth_sent_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // mode is frozen for the whole capture and readout
      if (arm_take) bank_mode_q <= bank_mode_i;
      // a new arm opens a new report slot
      if (arm_take) depth_sent_q <= 1'b0;
      else if (state_q == HOLD) depth_sent_q <= 1'b1;
      // report goes up one cycle after entering HOLD
      if (cap_rst_take) depth_valid_q <= 1'b0;
      else if (depth_valid_q && depth_ready_i) depth_valid_q <= 1'b0;
      else if ((state_q == HOLD) && !depth_sent_q) depth_valid_q <= 1'b1;
    end
  end

  assign state_o         = state_q;
  assign bank_mode_o     = bank_mode_q;
  // counts restart on every arm and on a capture reset
  assign counter_clear_o = arm_take || cap_rst_take;
  assign readout_flush_o = rd_rst_take;
  assign depth_valid_o   = depth_valid_q;
  assign capture_ready_o = (state_q == ARMED);

endmodule

// File: common/capture_state_pkg.sv
// three-bit state code with five legal values; the remaining codes must never appear
package capture_state_pkg;

  // controller states in the order a normal capture visits them
  typedef enum logic [2:0] {
    // waiting for an arm pulse
    IDLE    = 3'd0,
    // armed, waiting for the hardware start trigger
    ARMED   = 3'd1,
    // samples are being written
    CAPTURE = 3'd2,
    // capture finished, depth report and readout start accepted here
    HOLD    = 3'd3,
    // stored samples are streamed out
    READOUT = 3'd4
  } capture_state_t;

endpackage

// File: common/buffer_cfg_pkg.sv
// CHANNELS is fixed at 2 and the banking logic relies on it; SAMPLE_WIDTH may be changed freely
package buffer_cfg_pkg;

  // number of input channels, one bank per channel
  localparam int CHANNELS = 2;

  // bits per stored sample
  localparam int SAMPLE_WIDTH = 16;

  // width of a bank select, derived from the channel count
  localparam int BANK_SEL_WIDTH = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  // banking mode, latched when the capture is armed
  // all channels puts channel c in bank c
  // channel 0 only runs channel 0 through every bank in turn
  typedef enum logic {
    MODE_ALL_CHANNELS = 1'b0,
    MODE_CH0_ONLY     = 1'b1
  } bank_mode_t;

endpackage
